// ==== conv_cfg_pkg.sv ====
`default_nettype none

package conv_cfg_pkg;

    localparam int KERNEL_SIZE = 3;                 // Window edge in pixels

    typedef logic        [7:0]  pix_t;              // Unsigned input pixel
    typedef logic signed [7:0]  coef_t;             // Signed kernel tap
    typedef logic signed [31:0] sum_t;              // Window sum, wraps at 32 bits
    typedef logic        [15:0] dim_t;              // Image size or position

    // Index c*K+r selects column c, row r
    typedef coef_t [KERNEL_SIZE*KERNEL_SIZE-1:0] coef_set_t;

    // Register map, byte offsets
    localparam int unsigned REG_WIDTH     = 'h00;
    localparam int unsigned REG_HEIGHT    = 'h04;
    localparam int unsigned REG_CTRL      = 'h08;   // bit0 start
    localparam int unsigned REG_STATUS    = 'h0C;   // bit0 busy, read only
    localparam int unsigned REG_RESULT    = 'h10;   // Last accepted sum, read only
    localparam int unsigned REG_COEF_BASE = 'h20;   // Tap i at base + 4*i

    typedef struct packed {
        logic start;
        dim_t width;
        dim_t height;
    } ctrl_s;

endpackage

`default_nettype wire

// ==== conv_data_pkg.sv ====
`default_nettype none

package conv_data_pkg;

    import conv_cfg_pkg::*;

    localparam int COL_IDX_W = $clog2(KERNEL_SIZE);    // Bits for a window column number

    // One window column, top row at index 0
    typedef struct packed {
        pix_t [KERNEL_SIZE-1:0] pix;
        logic [COL_IDX_W-1:0]   col_idx;                // 0 is the leftmost column
        logic                   last_col;               // Closes the window
        logic                   last_img;               // Closes the image
    } pix_col_s;

    typedef struct packed {
        sum_t sum;
        logic last_col;
        logic last_img;
    } col_sum_s;

    typedef struct packed {
        sum_t sum;
        logic last;
    } result_s;

endpackage

`default_nettype wire

// ==== conv_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_regs
    import conv_cfg_pkg::*;
    import conv_data_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  wire                    axi_clk,
    input  wire                    rst_n,
    // AXI4-lite slave
    input  wire [ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  wire                    s_axi_awvalid,
    output logic                   s_axi_awready,
    input  wire [31:0]             s_axi_wdata,
    input  wire                    s_axi_wvalid,
    output logic                   s_axi_wready,
    output logic                   s_axi_bvalid,
    input  wire                    s_axi_bready,
    input  wire [ADDR_WIDTH-1:0]   s_axi_araddr,
    input  wire                    s_axi_arvalid,
    output logic                   s_axi_arready,
    output logic [31:0]            s_axi_rdata,
    output logic                   s_axi_rvalid,
    input  wire                    s_axi_rready,
    // Engine side
    output ctrl_s                  ctrl,
    output coef_set_t              coefs,
    input  wire                    result_accepted,
    input  wire result_s           result,
    input  wire                    final_accepted
);

    logic [ADDR_WIDTH-1:0] wr_addr, rd_addr;   // Latched addresses
    logic [31:0]           wr_data;
    logic                  wr_fire;            // Both halves of a write are held
    logic                  busy;
    sum_t                  last_sum;           // Read back at REG_RESULT
    logic [31:0]           rd_mux;

    assign wr_fire = !s_axi_awready && !s_axi_wready && !s_axi_bvalid;

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes and control state
    always_ff @(posedge axi_clk or negedge rst_n) begin
        if (!rst_n) begin
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
            s_axi_bvalid  <= 1'b0;
            s_axi_arready <= 1'b1;
            s_axi_rvalid  <= 1'b0;
            ctrl          <= '0;
            busy          <= 1'b0;
        end else begin
            if (s_axi_awvalid && s_axi_awready) s_axi_awready <= 1'b0;  // aw taken
            if (s_axi_wvalid && s_axi_wready)   s_axi_wready  <= 1'b0;  // w taken
            if (final_accepted) begin       // Start self-clears once the image is done
                ctrl.start <= 1'b0;
                busy       <= 1'b0;
            end
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
                case (wr_addr)
                    ADDR_WIDTH'(REG_WIDTH):  ctrl.width  <= wr_data[15:0];
                    ADDR_WIDTH'(REG_HEIGHT): ctrl.height <= wr_data[15:0];
                    ADDR_WIDTH'(REG_CTRL): begin
                        ctrl.start <= wr_data[0];
                        if (wr_data[0]) busy <= 1'b1;
                    end
                    default: ;                  // Coefficients handled below
                endcase
            end
            if (s_axi_bvalid && s_axi_bready) begin   // Reopen once the response is taken
                s_axi_bvalid  <= 1'b0;
                s_axi_awready <= 1'b1;
                s_axi_wready  <= 1'b1;
            end
            // Read channel
            if (s_axi_arvalid && s_axi_arready) s_axi_arready <= 1'b0;
            else if (!s_axi_arready && !s_axi_rvalid) s_axi_rvalid <= 1'b1;
            if (s_axi_rvalid && s_axi_rready) begin
                s_axi_rvalid  <= 1'b0;
                s_axi_arready <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload latches, taps and result capture
    always_ff @(posedge axi_clk) begin
        if (s_axi_awvalid && s_axi_awready) wr_addr <= s_axi_awaddr;
        if (s_axi_wvalid && s_axi_wready)   wr_data <= s_axi_wdata;
        if (s_axi_arvalid && s_axi_arready) rd_addr <= s_axi_araddr;
        if (!s_axi_arready && !s_axi_rvalid) s_axi_rdata <= rd_mux;  // Data with rvalid
        if (result_accepted) last_sum <= result.sum;
        for (int i = 0; i < KERNEL_SIZE*KERNEL_SIZE; i++) begin
            if (wr_fire && wr_addr == ADDR_WIDTH'(REG_COEF_BASE + 4*i))
                coefs[i] <= wr_data[7:0];
        end
    end

    // Read decode with zero for unmapped addresses
    always_comb begin
        rd_mux = '0;
        case (rd_addr)
            ADDR_WIDTH'(REG_WIDTH):  rd_mux = 32'(ctrl.width);
            ADDR_WIDTH'(REG_HEIGHT): rd_mux = 32'(ctrl.height);
            ADDR_WIDTH'(REG_CTRL):   rd_mux = 32'(ctrl.start);
            ADDR_WIDTH'(REG_STATUS): rd_mux = 32'(busy);
            ADDR_WIDTH'(REG_RESULT): rd_mux = last_sum;
            default: ;
        endcase
        for (int i = 0; i < KERNEL_SIZE*KERNEL_SIZE; i++) begin
            if (rd_addr == ADDR_WIDTH'(REG_COEF_BASE + 4*i))
                rd_mux = 32'(signed'(coefs[i]));   // Sign-extended tap
        end
    end

endmodule

`default_nettype wire

// ==== conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_top
    import conv_cfg_pkg::*;
    import conv_data_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  wire                  axi_clk,
    input  wire                  rst_n,
    // AXI4-lite register port
    input  wire [ADDR_WIDTH-1:0] s_axi_awaddr,
    input  wire                  s_axi_awvalid,
    output logic                 s_axi_awready,
    input  wire [31:0]           s_axi_wdata,
    input  wire                  s_axi_wvalid,
    output logic                 s_axi_wready,
    output logic                 s_axi_bvalid,
    input  wire                  s_axi_bready,
    input  wire [ADDR_WIDTH-1:0] s_axi_araddr,
    input  wire                  s_axi_arvalid,
    output logic                 s_axi_arready,
    output logic [31:0]          s_axi_rdata,
    output logic                 s_axi_rvalid,
    input  wire                  s_axi_rready,
    // Pixel input stream
    input  wire                  s_axis_valid,
    input  wire pix_t            s_axis_data,
    output logic                 s_axis_ready,
    // Sum output stream
    output logic                 m_axis_valid,
    output sum_t                 m_axis_data,
    output logic                 m_axis_last,
    input  wire                  m_axis_ready
);

    ctrl_s     ctrl;
    coef_set_t coefs;
    pix_col_s  col;                             // Loader to MAC
    logic      col_valid, col_ready;
    col_sum_s  col_sum;                         // MAC to accumulator
    logic      sum_valid, sum_ready;
    result_s   win_res;                         // Accumulator to output buffer
    logic      res_valid, res_ready;
    result_s   acc_res;                         // Accepted beat, back to registers
    logic      result_accepted, final_accepted;

    conv_regs #(.ADDR_WIDTH(ADDR_WIDTH)) i_conv_regs (
        .axi_clk, .rst_n,
        .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bvalid, .s_axi_bready,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rdata, .s_axi_rvalid, .s_axi_rready,
        .ctrl, .coefs,
        .result_accepted, .result(acc_res), .final_accepted
    );

    window_loader i_window_loader (
        .axi_clk, .rst_n, .ctrl,
        .s_axis_valid, .s_axis_data, .s_axis_ready,
        .col_valid, .col, .col_ready
    );

    mac_column i_mac_column (
        .axi_clk, .rst_n, .coefs,
        .in_valid(col_valid), .in_col(col), .in_ready(col_ready),
        .out_valid(sum_valid), .out_sum(col_sum), .out_ready(sum_ready)
    );

    window_accumulator i_window_accumulator (
        .axi_clk, .rst_n,
        .in_valid(sum_valid), .in_sum(col_sum), .in_ready(sum_ready),
        .out_valid(res_valid), .out_result(win_res), .out_ready(res_ready)
    );

    result_stream i_result_stream (
        .axi_clk, .rst_n,
        .in_valid(res_valid), .in_result(win_res), .in_ready(res_ready),
        .m_axis_valid, .m_axis_data, .m_axis_last, .m_axis_ready,
        .result_accepted, .result(acc_res), .final_accepted
    );

endmodule

`default_nettype wire

// ==== list.f ====
conv_cfg_pkg.sv
conv_data_pkg.sv
conv_regs.sv
window_loader.sv
mac_column.sv
window_accumulator.sv
result_stream.sv
conv_top.sv
tb_conv_top.sv

// ==== mac_column.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_column
    import conv_cfg_pkg::*;
    import conv_data_pkg::*;
(
    input  wire            axi_clk,
    input  wire            rst_n,
    input  wire coef_set_t coefs,
    input  wire            in_valid,
    input  wire pix_col_s  in_col,
    output logic           in_ready,
    output logic           out_valid,
    output col_sum_s       out_sum,
    input  wire            out_ready
);

    sum_t col_acc;                      // Combinational column dot product

    assign in_ready = !out_valid || out_ready;     // Empty or draining

    // A zero top bit keeps the unsigned pixel positive in the signed multiply
    always_comb begin
        col_acc = '0;
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            col_acc = col_acc + sum_t'($signed({1'b0, in_col.pix[r]}))
                      * sum_t'(coefs[in_col.col_idx*KERNEL_SIZE + r]);
        end
    end

    always_ff @(posedge axi_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (in_valid && in_ready) begin
            out_sum.sum      <= col_acc;
            out_sum.last_col <= in_col.last_col;   // Flags ride along
            out_sum.last_img <= in_col.last_img;
        end
    end

endmodule

`default_nettype wire

// ==== result_stream.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stream
    import conv_cfg_pkg::*;
    import conv_data_pkg::*;
(
    input  wire          axi_clk,
    input  wire          rst_n,
    input  wire          in_valid,
    input  wire result_s in_result,
    output logic         in_ready,
    // AXI4-stream master
    output logic         m_axis_valid,
    output sum_t         m_axis_data,
    output logic         m_axis_last,
    input  wire          m_axis_ready,
    // Reports to the register file
    output logic         result_accepted,
    output result_s      result,
    output logic         final_accepted
);

    result_s    mem [2];            // Two-entry store
    logic       wr_ptr, rd_ptr;
    logic [1:0] count;              // Entries held, 0 to 2
    logic       push, pop;

    assign in_ready     = (count != 2'd2);     // Ready while a slot is free
    assign m_axis_valid = (count != 2'd0);
    assign push         = in_valid && in_ready;
    assign pop          = m_axis_valid && m_axis_ready;

    assign result          = mem[rd_ptr];      // Head entry
    assign m_axis_data     = result.sum;
    assign m_axis_last     = result.last;
    assign result_accepted = pop;
    assign final_accepted  = pop && result.last;

    always_ff @(posedge axi_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop)  rd_ptr <= !rd_ptr;
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge axi_clk) begin
        if (push) mem[wr_ptr] <= in_result;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_top -f list.f -o sim_conv
out=$(./obj_dir/sim_conv)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== tb_conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top
    import conv_cfg_pkg::*;
();

    localparam int K           = KERNEL_SIZE;
    localparam int ADDR_W      = 8;
    localparam int MAX_DIM     = 12;        // Largest random image edge
    localparam int BUS_WAIT    = 100;       // Cycles per register handshake
    localparam int STREAM_WAIT = 2000;      // Cycles without stream progress

    logic              axi_clk = 1'b0;
    logic              rst_n;
    logic [ADDR_W-1:0] s_axi_awaddr, s_axi_araddr;
    logic              s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
    logic [31:0]       s_axi_wdata, s_axi_rdata;
    logic              s_axi_bvalid, s_axi_bready;
    logic              s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
    logic              s_axis_valid, s_axis_ready;
    pix_t              s_axis_data;
    logic              m_axis_valid, m_axis_last, m_axis_ready;
    sum_t              m_axis_data;

    // Reference image and model state
    int width, height;
    int img [MAX_DIM][MAX_DIM];             // [row][column]
    int coef [K*K];                         // Column c, row r at c*K+r
    int exp_q [$];                          // Expected sums, row-major windows
    int checks, errors, timeouts;
    int sums_seen;                          // Output beats accepted for this image

    conv_top i_conv_top (.*);

    always #2 axi_clk = ~axi_clk;           // 4 ns period

    ////////////////////////////////////////////////////////////////////////////
    // Checking helpers
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s got %0d expected %0d", $time, what,
                     $signed(actual), $signed(expected));
        end
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-lite master tasks start just after a rising edge
    task automatic axi_write(input int addr, input logic [31:0] data);
        int   t;
        logic aw_done, w_done, b_done;
        t       = 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        b_done  = 1'b0;
        s_axi_awaddr  <= ADDR_W'(addr);
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wvalid  <= 1'b1;
        while (!(aw_done && w_done) && t < BUS_WAIT) begin
            @(posedge axi_clk);
            t++;
            if (s_axi_awvalid && s_axi_awready) begin   // Address taken
                aw_done = 1'b1;
                s_axi_awvalid <= 1'b0;
            end
            if (s_axi_wvalid && s_axi_wready) begin     // Data taken
                w_done = 1'b1;
                s_axi_wvalid <= 1'b0;
            end
        end
        if (!(aw_done && w_done)) timed_out("write address and data ready");
        s_axi_bready <= 1'b1;
        t = 0;
        while (!b_done && t < BUS_WAIT) begin
            @(posedge axi_clk);
            t++;
            b_done = s_axi_bvalid && s_axi_bready;
        end
        s_axi_bready <= 1'b0;
        if (!b_done) timed_out("write response");
    endtask

    task automatic axi_read(input int addr, output logic [31:0] data);
        int   t;
        logic ar_done, r_done;
        t       = 0;
        ar_done = 1'b0;
        r_done  = 1'b0;
        data    = '0;
        s_axi_araddr  <= ADDR_W'(addr);
        s_axi_arvalid <= 1'b1;
        while (!ar_done && t < BUS_WAIT) begin
            @(posedge axi_clk);
            t++;
            ar_done = s_axi_arvalid && s_axi_arready;
        end
        s_axi_arvalid <= 1'b0;
        if (!ar_done) timed_out("read address ready");
        s_axi_rready <= 1'b1;
        t = 0;
        while (!r_done && t < BUS_WAIT) begin
            @(posedge axi_clk);
            t++;
            r_done = s_axi_rvalid && s_axi_rready;
            if (r_done) data = s_axi_rdata;             // Held with rvalid
        end
        s_axi_rready <= 1'b0;
        if (!r_done) timed_out("read data");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Random image, kernel and expected sums
    function automatic void make_image();
        int s;
        width  = K + int'($urandom % (MAX_DIM - K + 1));
        height = K + int'($urandom % (MAX_DIM - K + 1));
        foreach (coef[i]) coef[i] = int'($urandom % 256) - 128;   // Signed taps
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) img[y][x] = int'($urandom % 256);
        end
        exp_q.delete();
        for (int wy = 0; wy <= height - K; wy++) begin
            for (int wx = 0; wx <= width - K; wx++) begin
                s = 0;                                  // int arithmetic wraps at 32 bits
                for (int c = 0; c < K; c++) begin
                    for (int r = 0; r < K; r++) s += img[wy+r][wx+c] * coef[c*K+r];
                end
                exp_q.push_back(s);
            end
        end
    endfunction

    task automatic program_image();
        logic [31:0] rd;
        axi_write(REG_WIDTH, 32'(width));
        axi_write(REG_HEIGHT, 32'(height));
        foreach (coef[i]) axi_write(REG_COEF_BASE + 4*i, 32'(coef[i]));
        axi_read(REG_WIDTH, rd);
        check_value(rd, 32'(width), "width readback");
        axi_read(REG_HEIGHT, rd);
        check_value(rd, 32'(height), "height readback");
        foreach (coef[i]) begin
            axi_read(REG_COEF_BASE + 4*i, rd);
            check_value(rd, 32'(coef[i]), "coefficient readback");  // Sign-extended
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Pixel feeder that reloads all columns for every row of windows
    task automatic feed_pixels();
        pix_t beats [$];
        int   idx;
        int   t;
        for (int wy = 0; wy <= height - K; wy++) begin
            for (int x = 0; x < width; x++) begin
                for (int r = 0; r < K; r++) beats.push_back(pix_t'(img[wy+r][x]));
            end
        end
        idx = 0;
        t   = 0;
        while (idx < beats.size() && t < STREAM_WAIT) begin
            @(posedge axi_clk);
            t++;
            if (s_axis_valid && s_axis_ready) begin
                idx++;
                t = 0;
            end
            // A pending beat stays put until taken
            if (idx < beats.size() && (!s_axis_valid || s_axis_ready)) begin
                s_axis_valid <= ($urandom % 4) != 0;    // Random input gaps
                s_axis_data  <= beats[idx];
            end
        end
        s_axis_valid <= 1'b0;
        if (idx < beats.size()) timed_out("input stream ready");
    endtask

    // Output sink with random back-pressure
    task automatic collect_sums();
        int n;
        int got;
        int t;
        n   = exp_q.size();
        got = 0;
        t   = 0;
        while (got < n && t < STREAM_WAIT) begin
            @(posedge axi_clk);
            t++;
            if (m_axis_valid && m_axis_ready) begin
                check_value(m_axis_data, exp_q[got], "window sum");
                check_value(32'(m_axis_last), 32'(got == n - 1), "last flag");
                got++;
                t = 0;
            end
            m_axis_ready <= ($urandom % 3) != 0;
        end
        if (got < n) timed_out("output sum");
        sums_seen = got;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        void'($urandom(8268));
        rst_n         <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b0;
        s_axis_valid  <= 1'b0;
        s_axis_data   <= '0;
        m_axis_ready  <= 1'b0;
        repeat (8) @(posedge axi_clk);
        rst_n <= 1'b1;
        @(posedge axi_clk);
        axi_read(REG_STATUS, rd);
        check_value(rd, 32'd0, "busy after reset");
        for (int img_no = 0; img_no < 3 && timeouts == 0; img_no++) begin
            make_image();
            program_image();
            axi_write(REG_CTRL, 32'd1);                 // Start bit
            fork
                feed_pixels();
                collect_sums();
            join
            m_axis_ready <= 1'b1;
            repeat (16) begin                           // Late beats count as extra sums
                @(posedge axi_clk);
                if (m_axis_valid && m_axis_ready) sums_seen++;
            end
            check_value(32'(sums_seen), 32'((width - K + 1) * (height - K + 1)),
                        "sum count");
            axi_read(REG_CTRL, rd);
            check_value(rd, 32'd0, "start after final sum");
            axi_read(REG_STATUS, rd);
            check_value(rd, 32'd0, "busy after final sum");
            axi_read(REG_RESULT, rd);
            check_value(rd, exp_q[exp_q.size()-1], "result register");
        end
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== window_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_accumulator
    import conv_cfg_pkg::*;
    import conv_data_pkg::*;
(
    input  wire           axi_clk,
    input  wire           rst_n,
    input  wire           in_valid,
    input  wire col_sum_s in_sum,
    output logic          in_ready,
    output logic          out_valid,
    output result_s       out_result,
    input  wire           out_ready
);

    localparam int CNT_W = $clog2(KERNEL_SIZE + 1);

    sum_t             total;            // Running window total
    logic [CNT_W-1:0] col_cnt;          // Columns added so far
    logic [CNT_W-1:0] win_cnt;          // Columns in the presented result
    logic             take;

    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge axi_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            total     <= '0;
            col_cnt   <= '0;
        end else begin
            if (out_ready) out_valid <= 1'b0;
            if (take) begin
                if (in_sum.last_col) begin          // Window closes, restart
                    total     <= '0;
                    col_cnt   <= '0;
                    out_valid <= 1'b1;
                end else begin
                    total   <= total + in_sum.sum;
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (take && in_sum.last_col) begin
            out_result.sum  <= total + in_sum.sum;
            out_result.last <= in_sum.last_img;
            win_cnt         <= col_cnt + 1'b1;
        end
    end

    // Loader tagging and MAC ordering must give exactly K columns per window
    a_full_window: assert property (@(posedge axi_clk) disable iff (!rst_n)
        out_valid |-> win_cnt == CNT_W'(KERNEL_SIZE));

endmodule

`default_nettype wire

// ==== window_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_loader
    import conv_cfg_pkg::*;
    import conv_data_pkg::*;
(
    input  wire         axi_clk,
    input  wire         rst_n,
    input  wire ctrl_s  ctrl,
    // AXI4-stream slave, one pixel per beat
    input  wire         s_axis_valid,
    input  wire pix_t   s_axis_data,
    output logic        s_axis_ready,
    // Column link to the MAC
    output logic        col_valid,
    output pix_col_s    col,
    input  wire         col_ready
);

    localparam logic [COL_IDX_W-1:0] LAST_IDX = COL_IDX_W'(KERNEL_SIZE - 1);

    typedef enum logic [1:0] {idle, fill, issue} state_e;

    state_e                                 state;
    pix_t [KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] win;   // [column][row]
    logic [COL_IDX_W-1:0] fill_col, fill_row;       // Next slot to write
    logic [COL_IDX_W-1:0] issue_idx;                // Column being sent
    dim_t                 x, y;                     // Window origin in the image
    logic                 start_q;                  // For start edge detect
    logic                 last_x, last_y;
    logic                 beat, col_fire, done;

    assign last_x   = (x == ctrl.width  - dim_t'(KERNEL_SIZE));
    assign last_y   = (y == ctrl.height - dim_t'(KERNEL_SIZE));
    assign beat     = s_axis_valid && s_axis_ready;
    assign col_fire = col_valid && col_ready;
    assign done     = col_fire && col.last_img;     // Image-last column leaves

    assign s_axis_ready = (state == fill) && ctrl.start;
    assign col_valid    = (state == issue);

    always_comb begin
        col.pix      = win[issue_idx];
        col.col_idx  = issue_idx;
        col.last_col = (issue_idx == LAST_IDX);
        col.last_img = col.last_col && last_x && last_y;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Position tracking FSM
    always_ff @(posedge axi_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            start_q   <= 1'b0;
            x         <= '0;
            y         <= '0;
            fill_col  <= '0;
            fill_row  <= '0;
            issue_idx <= '0;
        end else begin
            start_q <= ctrl.start;
            case (state)
                idle: if (ctrl.start && !start_q) begin    // New image
                    state    <= fill;
                    x        <= '0;
                    y        <= '0;
                    fill_col <= '0;
                    fill_row <= '0;
                end
                fill: if (beat) begin
                    if (fill_row == LAST_IDX) begin        // Column complete
                        fill_row <= '0;
                        if (fill_col == LAST_IDX) begin
                            state     <= issue;
                            issue_idx <= '0;
                        end else begin
                            fill_col <= fill_col + 1'b1;
                        end
                    end else begin
                        fill_row <= fill_row + 1'b1;
                    end
                end
                issue: if (col_fire) begin
                    if (!col.last_col) begin
                        issue_idx <= issue_idx + 1'b1;
                    end else if (done) begin
                        state <= idle;
                    end else begin
                        state    <= fill;
                        fill_row <= '0;
                        if (last_x) begin                  // Wrap to next row, full reload
                            x        <= '0;
                            y        <= y + 1'b1;
                            fill_col <= '0;
                        end else begin                     // Slide by one column
                            x        <= x + 1'b1;
                            fill_col <= LAST_IDX;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Column buffer, oldest column drops out on a slide
    always_ff @(posedge axi_clk) begin
        if (beat) begin
            win[fill_col][fill_row] <= s_axis_data;
        end else if (col_fire && col.last_col && !last_x) begin
            for (int c = 0; c < KERNEL_SIZE - 1; c++)
                win[c] <= win[c+1];
        end
    end

    a_col_stable: assert property (@(posedge axi_clk) disable iff (!rst_n)
        col_valid && !col_ready |=> col_valid && $stable(col));

endmodule

`default_nettype wire
